// File: sources.f
common/dcache_pkg.sv
dcache/lsu_align.sv
dcache/dcache.sv
logic/load_store_port.sv
logic/dcache_top.sv
bench/clock_gen.sv
bench/mem_model.sv
bench/tb_dcache.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ns --top-module tb_dcache \
	-f sources.f -o tb_dcache_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_dcache_sim > sim.log 2>&1
cat sim.log
grep -q "^Test passed$" sim.log && exit 0 || exit 1

// File: bench/tb_dcache.sv
`timescale 1ns/1ns

module tb_dcache;
	import dcache_pkg::*;

	localparam int mem_lines = 1024;
	localparam int wait_limit = 200;

	logic         clock;
	logic         reset;
	logic         req_valid;
	mem_req_t     req;
	logic         req_ready;
	logic         resp_valid;
	mem_resp_t    resp;
	mem_bus_req_t mem_req;
	mem_tag_t     mem_response;
	logic [63:0]  mem_data;
	mem_tag_t     mem_data_tag;
	logic         refuse;
	logic [2:0]   latency;

	logic [63:0]  image [mem_lines]; // expected memory contents
	mem_bus_req_t bus_log [$];       // accepted bus requests in arrival order
	logic [31:0]  stim_lfsr;
	logic [31:0]  knob_lfsr;
	int           mismatches;
	int           timeouts;
	int           other_errors;

	clock_gen #(.period(40), .reset_cycles(16)) clk0 (.clock(clock), .reset(reset));

	mem_model #(.max_pending(4)) mem0 (
		.clock        (clock),
		.reset        (reset),
		.mem_req      (mem_req),
		.refuse       (refuse),
		.latency      (latency),
		.mem_response (mem_response),
		.mem_data     (mem_data),
		.mem_data_tag (mem_data_tag)
	);

	dcache_top #(.lines(32)) dut0 (
		.clock        (clock),
		.reset        (reset),
		.req_valid    (req_valid),
		.req          (req),
		.req_ready    (req_ready),
		.resp_valid   (resp_valid),
		.resp         (resp),
		.mem_req      (mem_req),
		.mem_response (mem_response),
		.mem_data     (mem_data),
		.mem_data_tag (mem_data_tag)
	);

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32 22 2 1
	endfunction

	task automatic draw(inout logic [31:0] state, input int n, output logic [63:0] value);
		value = 64'h0;
		for (int i = 0; i < n; i++) begin
			state = lfsr_next(state);
			value = {value[62:0], state[0]};
		end
	endtask

	function automatic logic [63:0] fill_value(input int unsigned idx);
		logic [31:0] a;
		a = idx * 8;
		return {a * 32'h9e37_79b1, (a ^ 32'hc3a5_96f0) * 32'h85eb_ca6b};
	endfunction

	function automatic logic [63:0] lane_mask(input mem_size_t size);
		return (size == size_double) ? 64'hffff_ffff_ffff_ffff :
			((64'h1 << ((1 << int'(size)) * 8)) - 64'h1);
	endfunction

	// bit position of the lane holding the offset
	function automatic int lane_shift(input logic [2:0] offset, input mem_size_t size);
		return (int'(offset) & ~((1 << int'(size)) - 1)) * 8;
	endfunction

	function automatic logic [63:0] read_lane(input logic [63:0] line, input logic [2:0] offset,
			input mem_size_t size, input logic uns);
		logic [63:0] value;
		value = (line >> lane_shift(offset, size)) & lane_mask(size);
		if (!uns && size != size_double && value[(1 << int'(size)) * 8 - 1]) begin
			value = value | ~lane_mask(size);
		end
		return value;
	endfunction

	function automatic logic [63:0] write_lane(input logic [63:0] line, input logic [2:0] offset,
			input mem_size_t size, input logic [63:0] data);
		return (line & ~(lane_mask(size) << lane_shift(offset, size))) |
			((data & lane_mask(size)) << lane_shift(offset, size));
	endfunction

	function automatic int count_loads();
		int n;
		n = 0;
		foreach (bus_log[i]) begin
			if (bus_log[i].cmd == bus_load) begin
				n++;
			end
		end
		return n;
	endfunction

	task automatic check_resp(input string name, input mem_resp_t got, input mem_resp_t exp);
		if (got !== exp) begin
			$display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
			mismatches++;
		end
	endtask

	task automatic check_bus(input string name, input mem_bus_req_t got, input mem_bus_req_t exp);
		if (got !== exp) begin
			$display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
			mismatches++;
		end
	endtask

	task automatic check_cmd(input string name, input bus_cmd_t got, input bus_cmd_t exp);
		if (got !== exp) begin
			$display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
			mismatches++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
			mismatches++;
		end
	endtask

	task automatic next_cycle();
		@(posedge clock);
		#2;
	endtask

	task automatic wait_reset();
		int n;
		n = 0;
		@(posedge clock);
		#3;
		while (reset !== 1'b0 && n < 100) begin
			@(posedge clock);
			#3; // just past the release point
			n++;
		end
		if (reset !== 1'b0) begin
			$display("timeout waiting for reset to be released");
			timeouts++;
		end
	endtask

	// drives one request and checks the response against the image
	task automatic run_op(input bus_cmd_t cmd, input mem_size_t size, input logic uns,
			input logic [31:0] addr, input logic [63:0] data, output int edges);
		mem_resp_t exp;
		int        n;
		n = 0;
		edges = 0;
		while (!req_ready && n < wait_limit) begin
			next_cycle();
			n++;
		end
		if (!req_ready) begin
			$display("timeout waiting for req_ready before request to %h", addr);
			timeouts++;
			return;
		end
		req_valid = 1'b1;
		req = '{cmd: cmd, size: size, is_unsigned: uns, addr: addr, data: data};
		next_cycle();
		req_valid = 1'b0;
		while (!resp_valid && edges < wait_limit) begin
			check_flag("req_ready", req_ready, 1'b0); // busy until after the response
			next_cycle();
			edges++;
		end
		if (!resp_valid) begin
			$display("timeout waiting for resp_valid after request to %h", addr);
			timeouts++;
			return;
		end
		check_flag("req_ready", req_ready, 1'b0);
		if (cmd == bus_store) begin
			image[addr[12:3]] = write_lane(image[addr[12:3]], addr[2:0], size, data);
			exp = '{data: 64'h0, is_store: 1'b1};
		end else begin
			exp = '{data: read_lane(image[addr[12:3]], addr[2:0], size, uns), is_store: 1'b0};
		end
		check_resp($sformatf("resp for %h", addr), resp, exp);
	endtask

	task automatic reset_values();
		check_flag("req_ready", req_ready, 1'b1);
		check_flag("resp_valid", resp_valid, 1'b0);
		check_cmd("mem_req.cmd", mem_req.cmd, bus_none);
	endtask

	task automatic miss_then_hit();
		int edges;
		int loads;
		run_op(bus_load, size_double, 1'b0, 32'h40, 64'h0, edges);
		loads = count_loads();
		if (loads == 0) begin
			$display("load miss to 00000040 issued no bus_load");
			other_errors++;
		end
		run_op(bus_load, size_word, 1'b1, 32'h44, 64'h0, edges);
		if (edges != 1) begin
			$display("hit response came %0d edges after accept instead of one", edges);
			other_errors++;
		end
		if (count_loads() != loads) begin
			$display("load hit to 00000044 issued a bus_load");
			other_errors++;
		end
	endtask

	task automatic size_extension();
		int edges;
		run_op(bus_load, size_double, 1'b0, 32'h80, 64'h0, edges); // bring the line in
		for (int s = 0; s < 3; s++) begin
			for (int off = 0; off < 8; off += (1 << s)) begin
				run_op(bus_load, mem_size_t'(s), 1'b0, 32'h80 + off, 64'h0, edges);
				run_op(bus_load, mem_size_t'(s), 1'b1, 32'h80 + off, 64'h0, edges);
			end
		end
	endtask

	task automatic store_merge();
		logic [63:0] bits;
		logic [63:0] value;
		int          edges;
		for (int s = 0; s < 4; s++) begin
			draw(stim_lfsr, 3, bits);
			draw(stim_lfsr, 64, value);
			run_op(bus_store, mem_size_t'(s), 1'b0, {29'h18, bits[2:0]}, value, edges);
			run_op(bus_load, size_double, 1'b0, 32'hc0, 64'h0, edges);
		end
	endtask

	task automatic dirty_eviction();
		mem_bus_req_t exp;
		int           edges;
		int           mark;
		run_op(bus_store, size_word, 1'b0, 32'h104, 64'hdead_beef, edges);
		mark = bus_log.size();
		run_op(bus_load, size_double, 1'b0, 32'h200, 64'h0, edges); // same index 0
		if (bus_log.size() != mark + 2) begin
			$display("eviction gave %0d bus requests, not one writeback and one refill",
				bus_log.size() - mark);
			other_errors++;
		end else begin
			exp = '{cmd: bus_store, addr: 32'h100, data: image[32]};
			check_bus("writeback", bus_log[mark], exp);
			exp = '{cmd: bus_load, addr: 32'h200, data: 64'h0};
			check_bus("refill", bus_log[mark + 1], exp);
		end
	endtask

	task automatic random_traffic();
		logic [63:0] bits;
		logic [63:0] data;
		logic [31:0] addr;
		int          edges;
		for (int i = 0; i < 200; i++) begin
			draw(stim_lfsr, 12, bits);
			draw(stim_lfsr, 64, data);
			addr = {21'h0, bits[2:0], 3'b000, bits[4:3], bits[7:5]}; // tag, index, offset
			run_op(bits[11] ? bus_store : bus_load, mem_size_t'(bits[9:8]), bits[10],
				addr, data, edges);
		end
	endtask

	// memory refusals and latencies drawn every cycle
	initial begin
		logic [63:0] bits;
		refuse = 1'b0;
		latency = 3'd0;
		knob_lfsr = 32'd88495;
		forever begin
			next_cycle();
			draw(knob_lfsr, 5, bits);
			refuse = bits[4] & bits[3]; // about one cycle in four
			latency = bits[2:0];
		end
	end

	always @(posedge clock) begin
		if (!reset && mem_req.cmd != bus_none && mem_response != 4'h0) begin
			bus_log.push_back(mem_req);
		end
	end

	initial begin
		req_valid = 1'b0;
		req = '0;
		mismatches = 0;
		timeouts = 0;
		other_errors = 0;
		stim_lfsr = 32'd88495;
		for (int i = 0; i < mem_lines; i++) begin
			image[i] = fill_value(i);
		end
		wait_reset();
		reset_values();
		next_cycle();
		miss_then_hit();
		size_extension();
		store_merge();
		dirty_eviction();
		random_traffic();
		$display("errors: %0d mismatches, %0d timeouts, %0d other",
			mismatches, timeouts, other_errors);
		if (mismatches + timeouts + other_errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// File: bench/mem_model.sv
`timescale 1ns/1ns

module mem_model #(
	parameter int max_pending = 4
) (
	input  logic                     clock,
	input  logic                     reset,
	input  dcache_pkg::mem_bus_req_t mem_req,
	input  logic                     refuse,  // hand out no tag next cycle
	input  logic [2:0]               latency, // data delay above the minimum of two
	output dcache_pkg::mem_tag_t     mem_response,
	output logic [63:0]              mem_data,
	output dcache_pkg::mem_tag_t     mem_data_tag
);
	import dcache_pkg::*;

	localparam int mem_lines = 1024; // 8 KB window, addr[12:3]

	typedef struct packed {
		mem_tag_t    tag;
		logic [63:0] data;
		int          due;
	} pending_t;

	logic [63:0] lines [mem_lines];
	pending_t    pending [$];

	// start contents of line idx, every address bit mixed in
	function automatic logic [63:0] fill_value(input int unsigned idx);
		logic [31:0] a;
		a = idx * 8;
		return {a * 32'h9e37_79b1, (a ^ 32'hc3a5_96f0) * 32'h85eb_ca6b};
	endfunction

	initial begin
		pending_t entry;
		mem_tag_t next_tag;
		logic     refuse_now;
		int       delay;
		int       cycle;
		mem_response = 4'h0;
		mem_data     = 64'h0;
		mem_data_tag = 4'h0;
		next_tag     = 4'h1;
		cycle        = 0;
		for (int i = 0; i < mem_lines; i++) begin
			lines[i] = fill_value(i);
		end
		forever begin
			@(posedge clock);
			refuse_now = refuse;
			delay = 2 + int'(latency);
			if (reset) begin
				pending.delete();
			end else if (mem_req.cmd != bus_none && mem_response != 4'h0) begin
				if (mem_req.cmd == bus_store) begin
					lines[mem_req.addr[12:3]] = mem_req.data; // writeback done on accept
				end else begin
					entry.tag  = mem_response;
					entry.data = lines[mem_req.addr[12:3]];
					entry.due  = cycle + delay;
					pending.push_back(entry);
				end
			end
			cycle++;
			#2;
			mem_data_tag = 4'h0;
			if (pending.size() > 0 && pending[0].due <= cycle) begin
				entry = pending.pop_front();
				mem_data_tag = entry.tag;
				mem_data     = entry.data;
			end
			mem_response = 4'h0;
			if (!reset && mem_req.cmd != bus_none && !refuse_now &&
					pending.size() < max_pending) begin
				mem_response = next_tag;
				next_tag = (next_tag == 4'hf) ? 4'h1 : next_tag + 4'h1; // zero is reserved
			end
		end
	end

endmodule

// File: bench/clock_gen.sv
`timescale 1ns/1ns

module clock_gen #(
	parameter int period = 40,
	parameter int reset_cycles = 16
) (
	output logic clock,
	output logic reset
);

	initial begin
		clock = 1'b0;
		forever #(period / 2) clock = ~clock;
	end

	// held over the first reset_cycles rising edges
	initial begin
		reset = 1'b1;
		repeat (reset_cycles) @(posedge clock);
		#2;
		reset = 1'b0;
	end

endmodule

// File: logic/dcache_top.sv
`timescale 1ns/1ns

module dcache_top #(
	parameter int lines = 32 // power of two
) (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     req_valid,
	input  dcache_pkg::mem_req_t     req,
	output logic                     req_ready,
	output logic                     resp_valid,
	output dcache_pkg::mem_resp_t    resp,
	output dcache_pkg::mem_bus_req_t mem_req,
	input  dcache_pkg::mem_tag_t     mem_response,
	input  logic [63:0]              mem_data,
	input  dcache_pkg::mem_tag_t     mem_data_tag
);
	import dcache_pkg::*;

	mem_req_t    cur_req;
	logic        cur_active;
	logic        done;
	logic [63:0] load_value;

	load_store_port port0 (
		.clock      (clock),
		.reset      (reset),
		.req_valid  (req_valid),
		.req        (req),
		.req_ready  (req_ready),
		.resp_valid (resp_valid),
		.resp       (resp),
		.cur_req    (cur_req),
		.cur_active (cur_active),
		.done       (done),
		.load_value (load_value)
	);

	dcache #(
		.lines (lines)
	) cache0 (
		.clock        (clock),
		.reset        (reset),
		.cur_req      (cur_req),
		.cur_active   (cur_active),
		.done         (done),
		.load_value   (load_value),
		.mem_req      (mem_req),
		.mem_response (mem_response),
		.mem_data     (mem_data),
		.mem_data_tag (mem_data_tag)
	);

endmodule

// File: logic/load_store_port.sv
`timescale 1ns/1ns

module load_store_port (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  req_valid,
	input  dcache_pkg::mem_req_t  req,
	output logic                  req_ready,
	output logic                  resp_valid,
	output dcache_pkg::mem_resp_t resp,
	output dcache_pkg::mem_req_t  cur_req,
	output logic                  cur_active,
	input  logic                  done,
	input  logic [63:0]           load_value
);
	import dcache_pkg::*;

	logic busy; // from acceptance through the response cycle
	logic accept;

	assign req_ready = !busy;
	assign accept = req_valid && req_ready;

	always_ff @(posedge clock) begin
		if (reset) begin
			busy       <= 1'b0;
			cur_active <= 1'b0;
			resp_valid <= 1'b0;
		end else begin
			resp_valid <= done; // one-cycle pulse, no back-pressure

			if (accept) begin
				busy       <= 1'b1;
				cur_active <= 1'b1;
			end else if (done) begin
				cur_active <= 1'b0;
			end

			// reopen once the response has been shown
			if (resp_valid) begin
				busy <= 1'b0;
			end
		end
	end

	// request stays put for the cache while cur_active is high
	always_ff @(posedge clock) begin
		if (accept) begin
			cur_req <= req;
		end
	end

	always_ff @(posedge clock) begin
		if (done) begin
			resp.is_store <= cur_req.cmd == bus_store;
			resp.data     <= (cur_req.cmd == bus_load) ? load_value : 64'h0;
		end
	end

endmodule

// File: dcache/dcache.sv
`timescale 1ns/1ns

module dcache #(
	parameter int lines = 32
) (
	input  logic                     clock,
	input  logic                     reset,
	input  dcache_pkg::mem_req_t     cur_req,
	input  logic                     cur_active,
	output logic                     done,
	output logic [63:0]              load_value,
	output dcache_pkg::mem_bus_req_t mem_req,
	input  dcache_pkg::mem_tag_t     mem_response,
	input  logic [63:0]              mem_data,
	input  dcache_pkg::mem_tag_t     mem_data_tag
);
	import dcache_pkg::*;

	localparam int index_bits = $clog2(lines);
	localparam int tag_bits = addr_bits - offset_bits - index_bits;

	// miss handling; hits are served straight from idle
	typedef enum logic [2:0] {
		idle,
		writeback,
		fetch_req,
		fetch_wait,
		finish
	} state_t;

	cache_line_t array_q [lines];

	state_t   state;
	state_t   state_next;
	mem_tag_t fetch_tag; // tag handed out for the pending line load

	logic [tag_bits-1:0]    tag;
	logic [index_bits-1:0]  index;
	logic [offset_bits-1:0] offset;

	cache_line_t          sel;
	logic                 hit;
	logic                 access;
	logic                 is_store;
	logic                 mem_taken;
	logic                 line_arrived;
	logic [addr_bits-1:0] victim_addr;
	logic [63:0]          merged_line;

	assign {tag, index, offset} = cur_req.addr;

	assign sel      = array_q[index];
	assign hit      = sel.valid && (sel.tag == line_tag_t'(tag));
	assign access   = cur_active && (cur_req.cmd != bus_none);
	assign is_store = cur_req.cmd == bus_store;

	// address of the line being evicted, from its own tag and the index
	assign victim_addr = {sel.tag[tag_bits-1:0], index, {offset_bits{1'b0}}};

	assign mem_taken    = mem_response != '0;
	assign line_arrived = (state == fetch_wait) && (mem_data_tag == fetch_tag);

	// a hit completes in idle, a miss completes on its replay in finish
	assign done = cur_active && (state == idle || state == finish) &&
		(hit || cur_req.cmd == bus_none);

	lsu_align align0 (
		.line_data   (sel.data),
		.offset      (offset),
		.size        (cur_req.size),
		.is_unsigned (cur_req.is_unsigned),
		.store_data  (cur_req.data),
		.merged_line (merged_line),
		.load_value  (load_value)
	);

	always_comb begin
		state_next = state;
		case (state)
			idle: begin
				if (access && !hit) begin
					state_next = (sel.valid && sel.dirty) ? writeback : fetch_req;
				end
			end
			writeback: if (mem_taken) state_next = fetch_req;
			fetch_req: if (mem_taken) state_next = fetch_wait;
			fetch_wait: if (line_arrived) state_next = finish;
			finish: state_next = idle;
			default: state_next = idle;
		endcase
	end

	// request held steady until memory hands back a tag
	always_comb begin
		mem_req.cmd  = bus_none;
		mem_req.addr = {tag, index, {offset_bits{1'b0}}};
		mem_req.data = '0;
		case (state)
			writeback: begin
				mem_req.cmd  = bus_store;
				mem_req.addr = victim_addr;
				mem_req.data = sel.data;
			end
			fetch_req: mem_req.cmd = bus_load;
			default: mem_req.cmd = bus_none;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= idle;
			for (int i = 0; i < lines; i++) begin
				array_q[i].valid <= 1'b0;
				array_q[i].dirty <= 1'b0;
			end
		end else begin
			state <= state_next;

			// accepted writeback is complete
			if (state == writeback && mem_taken) begin
				array_q[index].dirty <= 1'b0;
			end

			// install the fetched line clean
			if (line_arrived) begin
				array_q[index].valid <= 1'b1;
				array_q[index].dirty <= 1'b0;
				array_q[index].tag   <= line_tag_t'(tag);
				array_q[index].data  <= mem_data;
			end

			if (done && is_store) begin
				array_q[index].data  <= merged_line;
				array_q[index].dirty <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (state == fetch_req && mem_taken) begin
			fetch_tag <= mem_response;
		end
	end

endmodule

// File: dcache/lsu_align.sv
`timescale 1ns/1ns

module lsu_align (
	input  logic [63:0]           line_data,
	input  logic [2:0]            offset,
	input  dcache_pkg::mem_size_t size,
	input  logic                  is_unsigned,
	input  logic [63:0]           store_data,
	output logic [63:0]           merged_line,
	output logic [63:0]           load_value
);
	import dcache_pkg::*;

	// read views of the unmodified line
	logic [7:0][7:0]  rd_bytes;
	logic [3:0][15:0] rd_halves;
	logic [1:0][31:0] rd_words;

	// write views, patched with the store lane
	logic [7:0][7:0]  wr_bytes;
	logic [3:0][15:0] wr_halves;
	logic [1:0][31:0] wr_words;

	logic [7:0]  sel_byte;
	logic [15:0] sel_half;
	logic [31:0] sel_word;

	assign rd_bytes  = line_data;
	assign rd_halves = line_data;
	assign rd_words  = line_data;

	// low offset bits below the access size are dropped
	assign sel_byte = rd_bytes[offset];
	assign sel_half = rd_halves[offset[2:1]];
	assign sel_word = rd_words[offset[2]];

	always_comb begin
		wr_bytes    = line_data;
		wr_halves   = line_data;
		wr_words    = line_data;
		merged_line = line_data;
		case (size)
			size_byte: begin
				wr_bytes[offset] = store_data[7:0];
				merged_line = wr_bytes;
			end
			size_half: begin
				wr_halves[offset[2:1]] = store_data[15:0];
				merged_line = wr_halves;
			end
			size_word: begin
				wr_words[offset[2]] = store_data[31:0];
				merged_line = wr_words;
			end
			default: merged_line = store_data; // whole line
		endcase
	end

	always_comb begin
		case (size)
			size_byte: load_value = {{56{sel_byte[7] & ~is_unsigned}}, sel_byte};
			size_half: load_value = {{48{sel_half[15] & ~is_unsigned}}, sel_half};
			size_word: load_value = {{32{sel_word[31] & ~is_unsigned}}, sel_word};
			default:   load_value = line_data;
		endcase
	end

endmodule

// File: common/dcache_pkg.sv
package dcache_pkg;

	localparam int addr_bits = 32;
	localparam int offset_bits = 3; // 8-byte lines

	// widest tag a cache of any size may need
	// the cache stores its own tag right-aligned, zero-extended to this width
	localparam int line_tag_bits = addr_bits - offset_bits;

	// command on both the processor request and the memory bus
	typedef enum logic [1:0] {
		bus_none  = 2'h0,
		bus_load  = 2'h1,
		bus_store = 2'h2
	} bus_cmd_t;

	typedef enum logic [1:0] {
		size_byte   = 2'h0,
		size_half   = 2'h1,
		size_word   = 2'h2,
		size_double = 2'h3
	} mem_size_t;

	typedef logic [3:0] mem_tag_t; // 0 = no response this cycle

	typedef logic [line_tag_bits-1:0] line_tag_t;

	// one load or store from the processor
	typedef struct packed {
		bus_cmd_t              cmd;
		mem_size_t             size;
		logic                  is_unsigned;
		logic [addr_bits-1:0]  addr;
		logic [63:0]           data;  // store data, right-aligned
	} mem_req_t;

	typedef struct packed {
		logic [63:0] data;     // extended load value, zero for stores
		logic        is_store;
	} mem_resp_t;

	// request on the tagged memory bus, always a whole line
	typedef struct packed {
		bus_cmd_t              cmd;
		logic [addr_bits-1:0]  addr;
		logic [63:0]           data;
	} mem_bus_req_t;

	typedef struct packed {
		logic        valid;
		logic        dirty;
		line_tag_t   tag;
		logic [63:0] data;
	} cache_line_t;

endpackage
